//--- dv/fetch_chk.sv
`timescale 1ns/100ps

module fetch_chk (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          mem_idle,
    input logic                          ar_valid,
    input logic                          ar_ready,
    input logic [core_cfg_pkg::xlen-1:0] ar_addr,
    input logic                          instr_out_valid
);

    int          hold_fails = 0;
    int          settle_fails = 0;
    int          reset_fails = 0;
    int          idle_run;
    logic [31:0] fail_cnt;

    assign fail_cnt = hold_fails + settle_fails + reset_fails;

    // Run of idle cycles on the shared port, saturates at the settle count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idle_run <= 0;
        end else if (!mem_idle) begin
            idle_run <= 0;
        end else if (idle_run < core_cfg_pkg::settle_cycles) begin
            idle_run <= idle_run + 1;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
    else begin
        $error("ar_valid dropped or ar_addr changed before ar_ready");
        hold_fails++;
    end

    ar_settle: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ar_valid) |-> idle_run >= core_cfg_pkg::settle_cycles)
    else begin
        $error("ar_valid rose without enough idle cycles on the port");
        settle_fails++;
    end

    out_in_reset: assert property (@(posedge clk) !rst_n |-> !instr_out_valid)
    else begin
        $error("instr_out valid during reset");
        reset_fails++;
    end

endmodule

//--- dv/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb;

    localparam int xlen = core_cfg_pkg::xlen;

    // One fetch scenario and what the front end must produce for it
    typedef struct packed {
        logic [xlen-1:0] instr;
        logic [xlen-1:0] next_off;
        logic [3:0]      accept_dly;
        logic [3:0]      rsp_lat;
        logic [3:0]      gap_max;
        logic [3:0]      md_len;
        logic            foreign;
        logic            redir;
        logic [xlen-1:0] redir_pc;
    } row_t;

    logic                          clk;
    logic                          rst_n;
    logic                          mem_idle;
    logic                          ar_ready;
    logic                          ar_valid;
    logic [xlen-1:0]               ar_addr;
    logic [core_cfg_pkg::id_w-1:0] ar_id;
    logic                          r_valid;
    logic [core_cfg_pkg::id_w-1:0] r_id;
    logic [xlen-1:0]               r_data;
    fetch_pkg::redirect_t          redirect;
    logic                          md_busy;
    logic                          md_done;
    fetch_pkg::instr_out_t         instr_out;
    logic                          instr_out_valid;

    row_t            rows[$];
    logic [xlen-1:0] ref_pc;
    int              err_cnt;
    int              out_count = 0;
    int              exp_outs;
    int              seed;
    int              total;
    bit              stuck;

    fetch_top i_fetch_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_idle        (mem_idle),
        .ar_ready        (ar_ready),
        .ar_valid        (ar_valid),
        .ar_addr         (ar_addr),
        .ar_id           (ar_id),
        .r_valid         (r_valid),
        .r_id            (r_id),
        .r_data          (r_data),
        .redirect        (redirect),
        .md_busy         (md_busy),
        .md_done         (md_done),
        .instr_out       (instr_out),
        .instr_out_valid (instr_out_valid)
    );

    bind fetch_top fetch_chk i_fetch_chk (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_idle        (mem_idle),
        .ar_valid        (ar_valid),
        .ar_ready        (ar_ready),
        .ar_addr         (ar_addr),
        .instr_out_valid (instr_out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk) begin
        if (rst_n && instr_out_valid) begin
            out_count <= out_count + 1;
        end
    end

    // JAL with rd = x1 and the immediate scattered as imm[20|10:1|11|19:12]
    function automatic logic [xlen-1:0] jal_word(input int off);
        logic [20:0] imm;
        imm = off[20:0];
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, fetch_pkg::opc_jal};
    endfunction

    task automatic add_row(input logic [xlen-1:0] instr, input int off, input int dly,
                           input int lat, input int gap, input int md, input bit foreign,
                           input bit redir, input logic [xlen-1:0] target);
        row_t r;
        r.instr      = instr;
        r.next_off   = off;
        r.accept_dly = 4'(dly);
        r.rsp_lat    = 4'(lat);
        r.gap_max    = 4'(gap);
        r.md_len     = 4'(md);
        r.foreign    = foreign;
        r.redir      = redir;
        r.redir_pc   = target;
        rows.push_back(r);
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic await_request();
        int n;
        n = 0;
        @(negedge clk);
        while (!ar_valid && n < 64) begin
            @(negedge clk);
            n++;
        end
        if (!ar_valid) begin
            $display("Timeout, no fetch request appeared within 64 cycles");
            err_cnt++;
            stuck = 1'b1;
        end
    endtask

    task automatic collect_output();
        int n;
        n = 0;
        @(negedge clk);
        while (!instr_out_valid && n < 64) begin
            @(negedge clk);
            n++;
        end
        if (!instr_out_valid) begin
            $display("Timeout, no instruction came out within 64 cycles");
            err_cnt++;
            stuck = 1'b1;
        end
    endtask

    task automatic run_md(input int len);
        repeat (len) begin
            @(negedge clk);
            assert (!ar_valid) else begin
                $display("A fetch request went out while multiply/divide was busy");
                err_cnt++;
            end
        end
        @(posedge clk);
        md_busy <= 1'b0;
        md_done <= 1'b1;
        @(posedge clk);
        md_done <= 1'b0;
    endtask

    // Memory side that may send a response with a foreign ID before the real one
    task automatic send_response(input row_t r);
        repeat (r.rsp_lat) @(posedge clk);
        if (r.foreign) begin
            r_valid <= 1'b1;
            r_id    <= core_cfg_pkg::fetch_id ^ 4'h6;
            r_data  <= $random(seed);
            @(posedge clk);
            r_valid <= 1'b0;
            @(posedge clk);
        end
        r_valid <= 1'b1;
        r_id    <= core_cfg_pkg::fetch_id;
        r_data  <= r.instr;
        @(posedge clk);
        r_valid <= 1'b0;
        r_id    <= '0;
    endtask

    task automatic apply_row(input row_t r);
        logic [xlen-1:0] exp_next;
        int unsigned     rnd;
        int              gap;
        rnd = $random(seed);
        gap = int'(rnd % (32'(r.gap_max) + 32'd1));
        if (gap > 0) begin
            @(posedge clk);
            mem_idle <= 1'b0;
            repeat (gap) @(posedge clk);
            mem_idle <= 1'b1;
        end
        await_request();
        if (stuck) return;
        check_word("ar_addr", ref_pc, ar_addr);
        check_word("ar_id", 32'(core_cfg_pkg::fetch_id), 32'(ar_id));
        check_word("instr_out count", exp_outs, out_count);
        repeat (r.accept_dly) @(posedge clk);
        @(posedge clk);
        ar_ready <= 1'b1;
        @(posedge clk);
        ar_ready <= 1'b0;
        if (r.md_len != 0) md_busy <= 1'b1;
        if (r.redir) begin
            @(posedge clk);
            redirect.valid  <= 1'b1;
            redirect.target <= r.redir_pc;
            @(posedge clk);
            redirect.valid  <= 1'b0;
        end
        send_response(r);
        if (r.redir) begin
            ref_pc = r.redir_pc;
            return;
        end
        collect_output();
        if (stuck) return;
        exp_next = ref_pc + r.next_off;
        check_word("instr_out.pc", ref_pc, instr_out.pc);
        check_word("instr_out.instr", r.instr, instr_out.instr);
        check_word("instr_out.next_pc", exp_next, instr_out.next_pc);
        exp_outs++;
        ref_pc = exp_next;
        if (r.md_len != 0) run_md(int'(r.md_len));
    endtask

    // ************************************************************************
    // Stimulus table and main sequence
    // ************************************************************************

    task automatic build_table();
        //      instr               off    dly lat gap md fgn rdr target
        add_row(32'h0010_0093,      4,     0,  2,  3,  0, 0,  0,  '0);
        add_row(jal_word(256),      256,   2,  1,  0,  0, 0,  0,  '0);
        add_row(32'h0020_8133,      4,     1,  3,  5,  0, 1,  0,  '0);
        add_row(jal_word(-64),      -64,   0,  2,  2,  0, 0,  0,  '0);
        add_row(32'h0220_8033,      4,     1,  2,  0,  5, 0,  0,  '0);
        add_row(jal_word(-8),       -8,    3,  4,  1,  2, 1,  0,  '0);
        add_row(32'h0000_0013,      4,     1,  3,  0,  0, 0,  1,  32'h8000_2000);
        add_row(32'h0000_a183,      4,     2,  2,  4,  0, 1,  0,  '0);
        add_row(jal_word(2048),     2048,  0,  1,  2,  0, 0,  0,  '0);
        add_row(jal_word(-512),     -512,  1,  3,  0,  0, 1,  1,  32'h8000_0040);
    endtask

    initial begin
        seed     = 57548;
        err_cnt  = 0;
        exp_outs = 0;
        stuck    = 1'b0;
        ref_pc   = core_cfg_pkg::reset_pc;
        rst_n    <= 1'b0;
        mem_idle <= 1'b1;
        ar_ready <= 1'b0;
        r_valid  <= 1'b0;
        r_id     <= '0;
        r_data   <= '0;
        redirect <= '0;
        md_busy  <= 1'b0;
        md_done  <= 1'b0;
        build_table();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < rows.size() && !stuck; i++) begin
            apply_row(rows[i]);
        end
        // The last row's next PC shows up as one more request
        if (!stuck) begin
            await_request();
            if (!stuck) begin
                check_word("ar_addr", ref_pc, ar_addr);
                check_word("instr_out count", exp_outs, out_count);
            end
        end
        total = err_cnt + int'(i_fetch_top.i_fetch_chk.fail_cnt);
        $display("Run finished with %0d errors", total);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- logic/core_cfg_pkg.sv
package core_cfg_pkg;

    // ************************************************************************
    // Core-wide configuration
    // ************************************************************************

    // Address and instruction width
    localparam int xlen = 32;

    // First fetch address after reset
    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

    // Read transaction ID width and the ID owned by the fetch front end
    localparam int id_w = 4;
    localparam logic [id_w-1:0] fetch_id = 4'd1;

    // Consecutive idle cycles on the shared port before a fetch may go out
    localparam int settle_cycles = 4;

    // Wide enough to hold the idle count
    localparam int settle_w = $clog2(settle_cycles + 1);

endpackage

//--- logic/fetch_issue.sv
`timescale 1ns/100ps

module fetch_issue (
    input  logic                          clk,
    input  logic                          rst_n,
    input  fetch_pkg::pc_state_t          pc_state,
    input  fetch_pkg::redirect_t          redirect,
    input  logic                          mem_idle,
    input  logic                          ar_ready,
    output logic                          ar_valid,
    output logic [core_cfg_pkg::xlen-1:0] ar_addr,
    output logic [core_cfg_pkg::id_w-1:0] ar_id,
    input  logic                          r_valid,
    input  logic [core_cfg_pkg::id_w-1:0] r_id,
    input  logic [core_cfg_pkg::xlen-1:0] r_data,
    output logic                          raw_valid,
    output fetch_pkg::fetch_raw_t         raw
);

    typedef enum logic [1:0] {
        st_count,
        st_req,
        st_wait,
        st_finish
    } issue_fsm_t;

    issue_fsm_t                        state;
    logic [core_cfg_pkg::settle_w-1:0] idle_cnt;
    logic [core_cfg_pkg::xlen-1:0]     pc_q;
    logic                              stale_q;
    logic                              count_ok;
    logic                              issue_go;
    logic                              rsp_hit;

    // A redirect restarts the count so that the latched PC is never the old one
    assign count_ok = mem_idle && pc_state.ready && !redirect.valid;
    assign issue_go = (state == st_count) && count_ok &&
                      (idle_cnt == core_cfg_pkg::settle_w'(core_cfg_pkg::settle_cycles - 1));
    assign rsp_hit  = r_valid && (r_id == core_cfg_pkg::fetch_id);

    // ************************************************************************
    // Issue state machine
    // ************************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_count;
            idle_cnt <= '0;
            stale_q  <= 1'b0;
        end else begin
            case (state)
                st_count: begin
                    if (issue_go) begin
                        state    <= st_req;
                        idle_cnt <= '0;
                    end else if (count_ok) begin
                        idle_cnt <= idle_cnt + 1'b1;
                    end else begin
                        idle_cnt <= '0;
                    end
                end
                st_req: begin
                    // Address must stay up until accepted, even after a redirect
                    if (redirect.valid) stale_q <= 1'b1;
                    if (ar_ready) state <= st_wait;
                end
                st_wait: begin
                    if (redirect.valid) stale_q <= 1'b1;
                    if (rsp_hit) state <= st_finish;
                end
                st_finish: begin
                    state   <= st_count;
                    stale_q <= 1'b0;
                end
                default: begin
                    state <= st_count;
                end
            endcase
        end
    end

    // PC of the fetch in flight
    always_ff @(posedge clk) begin
        if (issue_go) begin
            pc_q <= pc_state.pc;
        end
    end

    assign ar_valid = (state == st_req);
    assign ar_addr  = pc_q;
    assign ar_id    = core_cfg_pkg::fetch_id;

    // Stale responses are still collected, they just go nowhere
    assign raw_valid = (state == st_wait) && rsp_hit && !stale_q && !redirect.valid;
    assign raw.pc    = pc_q;
    assign raw.instr = r_data;

endmodule

//--- logic/fetch_pkg.sv
package fetch_pkg;

    // ************************************************************************
    // Records passed between fetch stages
    // ************************************************************************

    // Current PC and whether pc_gen has no update waiting
    typedef struct packed {
        logic [core_cfg_pkg::xlen-1:0] pc;
        logic                          ready;
    } pc_state_t;

    // One returned fetch before predecode
    typedef struct packed {
        logic [core_cfg_pkg::xlen-1:0] pc;
        logic [core_cfg_pkg::xlen-1:0] instr;
    } fetch_raw_t;

    // Predecoded instruction as it leaves the front end
    typedef struct packed {
        logic [core_cfg_pkg::xlen-1:0] pc;
        logic [core_cfg_pkg::xlen-1:0] instr;
        logic [core_cfg_pkg::xlen-1:0] next_pc;
    } instr_out_t;

    // Control transfer requested by execute
    typedef struct packed {
        logic                          valid;
        logic [core_cfg_pkg::xlen-1:0] target;
    } redirect_t;

    // Major opcode of JAL
    localparam logic [6:0] opc_jal = 7'b110_1111;

endpackage

//--- logic/fetch_top.sv
`timescale 1ns/100ps

module fetch_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          mem_idle,
    input  logic                          ar_ready,
    output logic                          ar_valid,
    output logic [core_cfg_pkg::xlen-1:0] ar_addr,
    output logic [core_cfg_pkg::id_w-1:0] ar_id,
    input  logic                          r_valid,
    input  logic [core_cfg_pkg::id_w-1:0] r_id,
    input  logic [core_cfg_pkg::xlen-1:0] r_data,
    input  fetch_pkg::redirect_t          redirect,
    input  logic                          md_busy,
    input  logic                          md_done,
    output fetch_pkg::instr_out_t         instr_out,
    output logic                          instr_out_valid
);

    fetch_pkg::pc_state_t  pc_state;
    logic                  raw_valid;
    fetch_pkg::fetch_raw_t raw;
    logic                  raw_q_valid;
    fetch_pkg::fetch_raw_t raw_q;
    logic                  pd_valid;
    fetch_pkg::instr_out_t pd_instr;

    pc_gen i_pc_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .redirect  (redirect),
        .seq_valid (instr_out_valid),
        .seq_pc    (instr_out.next_pc),
        .md_busy   (md_busy),
        .md_done   (md_done),
        .pc_state  (pc_state)
    );

    fetch_issue i_fetch_issue (
        .clk       (clk),
        .rst_n     (rst_n),
        .pc_state  (pc_state),
        .redirect  (redirect),
        .mem_idle  (mem_idle),
        .ar_ready  (ar_ready),
        .ar_valid  (ar_valid),
        .ar_addr   (ar_addr),
        .ar_id     (ar_id),
        .r_valid   (r_valid),
        .r_id      (r_id),
        .r_data    (r_data),
        .raw_valid (raw_valid),
        .raw       (raw)
    );

    // Both stage boundaries are flushed by a redirect
    stage_reg #(.payload_t(fetch_pkg::fetch_raw_t)) i_raw_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (redirect.valid),
        .in_valid  (raw_valid),
        .in_data   (raw),
        .out_valid (raw_q_valid),
        .out_data  (raw_q)
    );

    predecode i_predecode (
        .in_valid  (raw_q_valid),
        .in_raw    (raw_q),
        .out_valid (pd_valid),
        .out_instr (pd_instr)
    );

    stage_reg #(.payload_t(fetch_pkg::instr_out_t)) i_out_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (redirect.valid),
        .in_valid  (pd_valid),
        .in_data   (pd_instr),
        .out_valid (instr_out_valid),
        .out_data  (instr_out)
    );

endmodule

//--- logic/pc_gen.sv
`timescale 1ns/100ps

module pc_gen (
    input  logic                          clk,
    input  logic                          rst_n,
    input  fetch_pkg::redirect_t          redirect,
    input  logic                          seq_valid,
    input  logic [core_cfg_pkg::xlen-1:0] seq_pc,
    input  logic                          md_busy,
    input  logic                          md_done,
    output fetch_pkg::pc_state_t          pc_state
);

    typedef enum logic [1:0] {
        st_idle,
        st_pending,
        st_apply
    } pc_fsm_t;

    pc_fsm_t                       state;
    pc_fsm_t                       state_nxt;
    logic [core_cfg_pkg::xlen-1:0] pc_q;
    logic [core_cfg_pkg::xlen-1:0] pc_nxt;
    logic [core_cfg_pkg::xlen-1:0] pend_pc_q;
    logic                          defer;

    // A sequential update has to wait while multiply/divide still runs
    assign defer = seq_valid && md_busy && !md_done;

    // ************************************************************************
    // Next PC selection
    // ************************************************************************

    always_comb begin
        state_nxt = state;
        pc_nxt    = pc_q;
        if (redirect.valid) begin
            // Execute wins and any deferred value is thrown away
            state_nxt = st_idle;
            pc_nxt    = redirect.target;
        end else begin
            case (state)
                st_idle: begin
                    if (defer) begin
                        state_nxt = st_pending;
                    end else if (seq_valid) begin
                        pc_nxt = seq_pc;
                    end
                end
                st_pending: begin
                    if (md_done) begin
                        state_nxt = st_apply;
                        pc_nxt    = pend_pc_q;
                    end
                end
                // One cycle so that fetch sees the new PC before it counts again
                st_apply: begin
                    state_nxt = st_idle;
                end
                default: begin
                    state_nxt = st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            pc_q  <= core_cfg_pkg::reset_pc;
        end else begin
            state <= state_nxt;
            pc_q  <= pc_nxt;
        end
    end

    // Parked next PC while the pending state is active
    always_ff @(posedge clk) begin
        if (state == st_idle && defer && !redirect.valid) begin
            pend_pc_q <= seq_pc;
        end
    end

    assign pc_state.pc    = pc_q;
    assign pc_state.ready = (state == st_idle);

endmodule

//--- logic/predecode.sv
`timescale 1ns/100ps

module predecode (
    input  logic                  in_valid,
    input  fetch_pkg::fetch_raw_t in_raw,
    output logic                  out_valid,
    output fetch_pkg::instr_out_t out_instr
);

    logic [6:0]                    opcode;
    logic                          is_jal;
    logic [core_cfg_pkg::xlen-1:0] j_imm;
    logic [core_cfg_pkg::xlen-1:0] seq_pc;
    logic [core_cfg_pkg::xlen-1:0] jal_pc;

    assign opcode = in_raw.instr[6:0];
    assign is_jal = (opcode == fetch_pkg::opc_jal);

    // ************************************************************************
    // J-type immediate, bit 0 is always zero
    // ************************************************************************

    assign j_imm = {
        {12{in_raw.instr[31]}},
        in_raw.instr[19:12],
        in_raw.instr[20],
        in_raw.instr[30:21],
        1'b0
    };

    assign seq_pc = in_raw.pc + core_cfg_pkg::xlen'(4);
    assign jal_pc = in_raw.pc + j_imm;

    assign out_valid         = in_valid;
    assign out_instr.pc      = in_raw.pc;
    assign out_instr.instr   = in_raw.instr;
    assign out_instr.next_pc = is_jal ? jal_pc : seq_pc;

endmodule

//--- logic/stage_reg.sv
`timescale 1ns/100ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // Valid bit is control state, flush wins over a new entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid && !flush;
        end
    end

    // Payload only moves when something valid arrives
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# Builds the fetch front end testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module fetch_tb

# Keep going after an assertion error so the testbench can report the total
out=$(./obj_dir/Vfetch_tb +verilator+error+limit+1000)
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
else
    exit 1
fi

//--- sim.f
logic/core_cfg_pkg.sv
logic/fetch_pkg.sv
logic/stage_reg.sv
logic/pc_gen.sv
logic/fetch_issue.sv
logic/predecode.sv
logic/fetch_top.sv
dv/fetch_chk.sv
dv/fetch_tb.sv
